/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_tx_streamer
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
verilog/tx_stream_pkg.sv
verilog/send_cmd_latch.sv
verilog/fragment_engine.sv
verilog/hdr_desc_regs.sv
verilog/dm_cmd_builder.sv
verilog/tx_streamer.sv
tests/tb_tx_streamer.sv

/* tests/tb_tx_streamer.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tx_streamer;

    localparam int BLOCK_SIZE      = 1024;
    localparam int BOUNDARY_SIZE   = 4096;
    localparam int NUM_CMDS        = 40;
    localparam int MAX_LEN         = 5000;
    localparam int MAX_FRAGS       = 6;
    localparam int CYCLES_PER_FRAG = 64;
    localparam int CYCLE_LIMIT     = NUM_CMDS * CYCLES_PER_FRAG * MAX_FRAGS;
    localparam tx_stream_pkg::len_t BLOCK_LEN = BLOCK_SIZE;
    localparam tx_stream_pkg::len_t BOUND_LEN = BOUNDARY_SIZE;

    logic aclk, aresetn;
    logic tx_cmd_valid, tx_cpl_ready;
    logic hdr_tx_busy, hdr_tx_done;
    logic m_axis_mm2s_cmd_tready, mm2s_rd_xfer_cmplt;
    tx_stream_pkg::sq_idx_t tx_cmd_sq_index;
    tx_stream_pkg::addr_t   tx_cmd_ddr_addr;
    tx_stream_pkg::len_t    tx_cmd_length;
    tx_stream_pkg::opcode_t tx_cmd_opcode;
    tx_stream_pkg::psn_t    tx_cmd_psn;
    tx_stream_pkg::qpn_t    tx_cmd_dest_qp;
    tx_stream_pkg::raddr_t  tx_cmd_remote_addr;
    tx_stream_pkg::rkey_t   tx_cmd_rkey;

    wire tx_cmd_ready, tx_cpl_valid, hdr_start_tx, hdr_more_fragments, m_axis_mm2s_cmd_tvalid;
    wire tx_stream_pkg::sq_idx_t  tx_cpl_sq_index;
    wire tx_stream_pkg::len_t     tx_cpl_bytes_sent;
    wire tx_stream_pkg::opcode_t  hdr_rdma_opcode;
    wire tx_stream_pkg::psn_t     hdr_rdma_psn;
    wire tx_stream_pkg::qpn_t     hdr_rdma_dest_qp;
    wire tx_stream_pkg::raddr_t   hdr_rdma_remote_addr;
    wire tx_stream_pkg::rkey_t    hdr_rdma_rkey;
    wire tx_stream_pkg::len_t     hdr_rdma_length;
    wire tx_stream_pkg::frag_id_t hdr_fragment_id;
    wire tx_stream_pkg::dm_cmd_t  m_axis_mm2s_cmd_tdata;

    // Expected fragments of the message in flight
    tx_stream_pkg::addr_t  exp_addr  [8];
    tx_stream_pkg::len_t   exp_len   [8];
    tx_stream_pkg::raddr_t exp_raddr [8];
    int exp_frags = 0;

    integer seed = 32'ha856;
    int errors = 0, cmds_done = 0, frag_total = 0, cycle_count = 0;
    int hdr_count = 0, dm_count = 0;
    logic in_flight = 1'b0, cpl_taken = 1'b0, hold_tdata = 1'b0, hold_cpl = 1'b0;
    tx_stream_pkg::dm_cmd_t last_tdata;

    tx_streamer #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .BOUNDARY_SIZE (BOUNDARY_SIZE)
    ) u_tx_streamer (.*);

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic print_summary();
        $display("Commands %0d, fragments %0d, errors %0d", cmds_done, frag_total, errors);
    endtask

    // Chunk is the least of remaining bytes, block size and room to the next boundary
    task automatic build_fragment_list(input tx_stream_pkg::addr_t addr,
                                       input tx_stream_pkg::len_t len,
                                       input tx_stream_pkg::raddr_t raddr);
        tx_stream_pkg::addr_t  a;
        tx_stream_pkg::len_t   rem;
        tx_stream_pkg::raddr_t r;
        tx_stream_pkg::len_t   room;
        tx_stream_pkg::len_t   chunk;
        a = addr;
        rem = len;
        r = raddr;
        exp_frags = 0;
        while (rem != 0 && exp_frags < 8) begin
            room  = BOUND_LEN - (a % BOUND_LEN);
            chunk = (rem > BLOCK_LEN) ? BLOCK_LEN : rem;
            if (chunk > room) begin
                chunk = room;
            end
            exp_addr[exp_frags]  = a;
            exp_len[exp_frags]   = chunk;
            exp_raddr[exp_frags] = r;
            a   = a + chunk;
            r   = r + tx_stream_pkg::raddr_t'(chunk);
            rem = rem - chunk;
            exp_frags++;
        end
    endtask

    task automatic check_header();
        check_rule(!hdr_tx_busy, "hdr_start_tx pulsed while hdr_tx_busy was high");
        if (hdr_count >= exp_frags) begin
            check_rule(1'b0, "more header start pulses than fragments in the message");
        end else begin
            check_value("hdr_length", 72'(exp_len[hdr_count]), 72'(hdr_rdma_length));
            check_value("hdr_remote_addr", 72'(exp_raddr[hdr_count]), 72'(hdr_rdma_remote_addr));
            check_value("hdr_fragment_id", 72'(hdr_count), 72'(hdr_fragment_id));
            check_value("hdr_more_fragments", 72'(hdr_count != exp_frags - 1),
                        72'(hdr_more_fragments));
        end
        check_value("hdr_opcode", 72'(tx_cmd_opcode), 72'(hdr_rdma_opcode));
        check_value("hdr_psn", 72'(tx_cmd_psn), 72'(hdr_rdma_psn));
        check_value("hdr_dest_qp", 72'(tx_cmd_dest_qp), 72'(hdr_rdma_dest_qp));
        check_value("hdr_rkey", 72'(tx_cmd_rkey), 72'(hdr_rdma_rkey));
        hdr_count++;
    endtask

    task automatic check_mm2s_word();
        tx_stream_pkg::dm_cmd_t w;
        tx_stream_pkg::addr_t   a;
        tx_stream_pkg::len_t    n;
        w = m_axis_mm2s_cmd_tdata;
        a = w[tx_stream_pkg::DM_ADDR_LSB +: 32];
        n = tx_stream_pkg::len_t'(w[tx_stream_pkg::DM_BTT_LSB +: 23]);
        if (dm_count >= exp_frags) begin
            check_rule(1'b0, "more MM2S commands than fragments in the message");
        end else begin
            check_value("mm2s_addr", 72'(exp_addr[dm_count]), 72'(a));
            check_value("mm2s_btt", 72'(exp_len[dm_count]), 72'(n));
        end
        check_value("mm2s_eof", 72'(1), 72'(w[tx_stream_pkg::DM_EOF_BIT]));
        check_value("mm2s_dsa", 72'(1), 72'(w[tx_stream_pkg::DM_DSA_BIT]));
        check_value("mm2s_type", 72'(0), 72'(w[tx_stream_pkg::DM_TYPE_BIT]));
        check_value("mm2s_reserved", 72'(0), 72'({w[71:64], w[29:24]}));
        check_rule(n != 0 && n <= BLOCK_LEN, "MM2S byte count is zero or above the block size");
        check_rule((a % BOUND_LEN) + n <= BOUND_LEN, "MM2S fragment crosses a boundary");
        dm_count++;
        frag_total++;
    endtask

    initial begin : clock_gen
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    //////////////////////////////////////////////////
    // Header inserter and data mover responders
    //////////////////////////////////////////////////

    // Busy may outlast the done pulse, which holds off the next start
    initial begin : header_inserter
        int d;
        hdr_tx_busy = 1'b0;
        hdr_tx_done = 1'b0;
        forever begin
            @(posedge aclk);
            if (aresetn && hdr_start_tx) begin
                @(negedge aclk);
                hdr_tx_busy = 1'b1;
                d = rand_below(8);
                repeat (d) @(negedge aclk);
                hdr_tx_done = 1'b1;
                @(negedge aclk);
                hdr_tx_done = 1'b0;
                d = rand_below(4);
                repeat (d) @(negedge aclk);
                hdr_tx_busy = 1'b0;
            end
        end
    end

    initial begin : ready_driver
        m_axis_mm2s_cmd_tready = 1'b0;
        forever begin
            @(negedge aclk);
            m_axis_mm2s_cmd_tready = (rand_below(4) != 0);
        end
    end

    initial begin : data_mover
        int d;
        mm2s_rd_xfer_cmplt = 1'b0;
        forever begin
            @(posedge aclk);
            if (aresetn && m_axis_mm2s_cmd_tvalid && m_axis_mm2s_cmd_tready) begin
                d = 1 + rand_below(8);
                repeat (d) @(negedge aclk);
                mm2s_rd_xfer_cmplt = 1'b1;
                @(negedge aclk);
                mm2s_rd_xfer_cmplt = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Monitor
    //////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn) begin
            if (in_flight) begin
                check_rule(!tx_cmd_ready, "tx_cmd_ready high while a message is in flight");
            end
            if (cpl_taken) begin
                check_rule(tx_cmd_ready, "tx_cmd_ready not high after the completion was taken");
            end
            cpl_taken = 1'b0;
            if (tx_cmd_valid && tx_cmd_ready) begin
                in_flight = 1'b1;
                hdr_count = 0;
                dm_count  = 0;
            end
            if (hdr_start_tx) begin
                check_header();
            end
            if (hold_tdata) begin
                check_rule(m_axis_mm2s_cmd_tvalid, "m_axis_mm2s_cmd_tvalid dropped before tready");
                check_value("mm2s_tdata_hold", last_tdata, m_axis_mm2s_cmd_tdata);
            end
            if (m_axis_mm2s_cmd_tvalid && m_axis_mm2s_cmd_tready) begin
                check_mm2s_word();
            end
            if (hold_cpl) begin
                check_rule(tx_cpl_valid, "tx_cpl_valid dropped before tx_cpl_ready");
            end
            if (tx_cpl_valid && tx_cpl_ready) begin
                check_value("cpl_sq_index", 72'(tx_cmd_sq_index), 72'(tx_cpl_sq_index));
                check_value("cpl_bytes_sent", 72'(tx_cmd_length), 72'(tx_cpl_bytes_sent));
                check_value("hdr_start_count", 72'(exp_frags), 72'(hdr_count));
                check_value("mm2s_cmd_count", 72'(exp_frags), 72'(dm_count));
                in_flight = 1'b0;
                cpl_taken = 1'b1;
                cmds_done++;
            end
            hold_tdata = m_axis_mm2s_cmd_tvalid && !m_axis_mm2s_cmd_tready;
            last_tdata = m_axis_mm2s_cmd_tdata;
            hold_cpl   = tx_cpl_valid && !tx_cpl_ready;
        end
    end

    initial begin : stimulus
        int d;
        aresetn            = 1'b0;
        tx_cmd_valid       = 1'b0;
        tx_cpl_ready       = 1'b0;
        tx_cmd_sq_index    = '0;
        tx_cmd_ddr_addr    = '0;
        tx_cmd_length      = '0;
        tx_cmd_opcode      = '0;
        tx_cmd_psn         = '0;
        tx_cmd_dest_qp     = '0;
        tx_cmd_remote_addr = '0;
        tx_cmd_rkey        = '0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        for (int i = 0; i < NUM_CMDS; i++) begin
            d = rand_below(5);
            repeat (d) @(negedge aclk);
            tx_cmd_sq_index    = tx_stream_pkg::sq_idx_t'($random(seed));
            tx_cmd_ddr_addr    = $random(seed);
            tx_cmd_length      = tx_stream_pkg::len_t'(1 + rand_below(MAX_LEN));
            tx_cmd_opcode      = tx_stream_pkg::opcode_t'($random(seed));
            tx_cmd_psn         = tx_stream_pkg::psn_t'($random(seed));
            tx_cmd_dest_qp     = tx_stream_pkg::qpn_t'($random(seed));
            tx_cmd_remote_addr = {$random(seed), $random(seed)};
            tx_cmd_rkey        = $random(seed);
            build_fragment_list(tx_cmd_ddr_addr, tx_cmd_length, tx_cmd_remote_addr);
            tx_cmd_valid = 1'b1;
            @(posedge aclk);
            while (!tx_cmd_ready) @(posedge aclk);
            @(negedge aclk);
            tx_cmd_valid = 1'b0;
            // Completion is held a few cycles before it is taken
            @(posedge aclk);
            while (!tx_cpl_valid) @(posedge aclk);
            d = rand_below(5);
            repeat (d + 1) @(negedge aclk);
            tx_cpl_ready = 1'b1;
            @(negedge aclk);
            tx_cpl_ready = 1'b0;
        end
        repeat (4) @(negedge aclk);
        check_value("commands_completed", 72'(NUM_CMDS), 72'(cmds_done));
        print_summary();
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/dm_cmd_builder.sv */
`timescale 1ns/1ns
`default_nettype none

module dm_cmd_builder (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire                       dm_issue,
    input  wire tx_stream_pkg::addr_t dm_addr,
    input  wire tx_stream_pkg::btt_t  dm_btt,
    output tx_stream_pkg::dm_cmd_t    m_axis_mm2s_cmd_tdata,
    output logic                      m_axis_mm2s_cmd_tvalid,
    input  wire                       m_axis_mm2s_cmd_tready
);

    tx_stream_pkg::dm_cmd_t cmd_word;

    // Single descriptor per fragment, EOF and DSA set, INCR burst type
    always_comb begin
        cmd_word = '0;
        cmd_word[tx_stream_pkg::DM_BTT_LSB +: $bits(tx_stream_pkg::btt_t)]   = dm_btt;
        cmd_word[tx_stream_pkg::DM_EOF_BIT]                                  = 1'b1;
        cmd_word[tx_stream_pkg::DM_DSA_BIT]                                  = 1'b1;
        cmd_word[tx_stream_pkg::DM_TYPE_BIT]                                 = 1'b0;
        cmd_word[tx_stream_pkg::DM_ADDR_LSB +: $bits(tx_stream_pkg::addr_t)] = dm_addr;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_axis_mm2s_cmd_tvalid <= 1'b0;
        end else if (dm_issue) begin
            m_axis_mm2s_cmd_tvalid <= 1'b1;
        end else if (m_axis_mm2s_cmd_tready) begin
            m_axis_mm2s_cmd_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (dm_issue) begin
            m_axis_mm2s_cmd_tdata <= cmd_word;
        end
    end

    a_tdata_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_mm2s_cmd_tvalid && !m_axis_mm2s_cmd_tready |=> $stable(m_axis_mm2s_cmd_tdata));

    // Engine must not overwrite a command the data mover has not taken
    a_no_overrun: assert property (@(posedge aclk) disable iff (!aresetn)
        dm_issue |-> !(m_axis_mm2s_cmd_tvalid && !m_axis_mm2s_cmd_tready));

endmodule

`default_nettype wire

/* verilog/fragment_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module fragment_engine #(
    parameter int BLOCK_SIZE    = 1024,
    parameter int BOUNDARY_SIZE = 1024
) (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire                        cmd_accept,
    input  wire tx_stream_pkg::addr_t  ddr_addr,
    input  wire tx_stream_pkg::len_t   length,
    input  wire tx_stream_pkg::raddr_t remote_addr,
    input  wire                        hdr_tx_busy,
    input  wire                        hdr_tx_done,
    input  wire                        mm2s_rd_xfer_cmplt,
    output logic                       hdr_load,
    output tx_stream_pkg::raddr_t      frag_remote_addr,
    output tx_stream_pkg::len_t        frag_len,
    output tx_stream_pkg::frag_id_t    frag_id,
    output logic                       frag_more,
    output logic                       dm_issue,
    output tx_stream_pkg::addr_t       dm_addr,
    output tx_stream_pkg::btt_t        dm_btt,
    output logic                       tx_cpl_valid,
    input  wire                        tx_cpl_ready,
    output tx_stream_pkg::len_t        tx_cpl_bytes_sent,
    output logic                       cmd_release
);

    localparam tx_stream_pkg::len_t BLOCK_LEN  = tx_stream_pkg::len_t'(BLOCK_SIZE);
    localparam tx_stream_pkg::len_t BOUND_LEN  = tx_stream_pkg::len_t'(BOUNDARY_SIZE);
    localparam tx_stream_pkg::len_t BOUND_MASK = BOUND_LEN - 1'b1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SIZE,
        S_LOAD,
        S_ISSUE,
        S_WAIT,
        S_UPDATE,
        S_CPL
    } state_t;

    state_t state;
    logic   first_frag;
    logic   done_seen;
    logic   xfer_seen;
    logic   both_seen;

    // Running position within the message
    tx_stream_pkg::len_t      rem_q;
    tx_stream_pkg::addr_t     addr_q;
    tx_stream_pkg::raddr_t    raddr_q;
    tx_stream_pkg::len_t      chunk_q;
    logic                     more_q;
    tx_stream_pkg::frag_id_t  id_q;
    tx_stream_pkg::len_t      sent_q;

    tx_stream_pkg::addr_t     cur_addr;
    tx_stream_pkg::len_t      cur_rem;
    tx_stream_pkg::raddr_t    cur_raddr;
    tx_stream_pkg::len_t      to_bound;
    tx_stream_pkg::len_t      by_block;
    tx_stream_pkg::len_t      chunk_d;

    //////////////////////////////////////////////////
    // Chunk sizing
    //////////////////////////////////////////////////

    // First fragment sizes straight from the latched command
    assign cur_addr  = first_frag ? ddr_addr    : addr_q;
    assign cur_rem   = first_frag ? length      : rem_q;
    assign cur_raddr = first_frag ? remote_addr : raddr_q;

    assign to_bound = BOUND_LEN - (cur_addr & BOUND_MASK);
    assign by_block = (cur_rem > BLOCK_LEN) ? BLOCK_LEN : cur_rem;
    assign chunk_d  = (by_block < to_bound) ? by_block : to_bound;

    // Either event may land first, or both in the same cycle
    assign both_seen = (done_seen || hdr_tx_done) && (xfer_seen || mm2s_rd_xfer_cmplt);

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= S_IDLE;
            first_frag <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_accept) begin
                        state      <= S_SIZE;
                        first_frag <= 1'b1;
                    end
                end
                S_SIZE: begin
                    state      <= S_LOAD;
                    first_frag <= 1'b0;
                end
                S_LOAD:   if (!hdr_tx_busy) state <= S_ISSUE;
                S_ISSUE:  state <= S_WAIT;
                S_WAIT:   if (both_seen) state <= S_UPDATE;
                S_UPDATE: state <= more_q ? S_SIZE : S_CPL;
                S_CPL:    if (tx_cpl_ready) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || state == S_UPDATE) begin
            done_seen <= 1'b0;
            xfer_seen <= 1'b0;
        end else begin
            if (hdr_tx_done) done_seen <= 1'b1;
            if (mm2s_rd_xfer_cmplt) xfer_seen <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_accept) begin
            id_q   <= '0;
            sent_q <= '0;
        end
        if (state == S_SIZE) begin
            rem_q   <= cur_rem;
            addr_q  <= cur_addr;
            raddr_q <= cur_raddr;
            chunk_q <= chunk_d;
            more_q  <= cur_rem > chunk_d;
        end
        if (state == S_UPDATE) begin
            rem_q   <= rem_q - chunk_q;
            addr_q  <= addr_q + chunk_q;
            raddr_q <= raddr_q + tx_stream_pkg::raddr_t'(chunk_q);
            id_q    <= id_q + 1'b1;
            sent_q  <= sent_q + chunk_q;
        end
    end

    assign hdr_load          = (state == S_LOAD) && !hdr_tx_busy;
    assign frag_remote_addr  = raddr_q;
    assign frag_len          = chunk_q;
    assign frag_id           = id_q;
    assign frag_more         = more_q;
    assign dm_issue          = (state == S_ISSUE);
    assign dm_addr           = addr_q;
    assign dm_btt            = tx_stream_pkg::btt_t'(chunk_q);
    assign tx_cpl_valid      = (state == S_CPL);
    assign tx_cpl_bytes_sent = sent_q;
    assign cmd_release       = tx_cpl_valid && tx_cpl_ready;

    a_chunk_range: assert property (@(posedge aclk) disable iff (!aresetn)
        dm_issue |-> (chunk_q != '0) && (chunk_q <= BLOCK_LEN));

endmodule

`default_nettype wire

/* verilog/hdr_desc_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module hdr_desc_regs (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire                          hdr_load,
    input  wire tx_stream_pkg::raddr_t   frag_remote_addr,
    input  wire tx_stream_pkg::len_t     frag_len,
    input  wire tx_stream_pkg::frag_id_t frag_id,
    input  wire                          frag_more,
    output logic                         hdr_start_tx,
    output tx_stream_pkg::raddr_t        hdr_rdma_remote_addr,
    output tx_stream_pkg::len_t          hdr_rdma_length,
    output tx_stream_pkg::frag_id_t      hdr_fragment_id,
    output logic                         hdr_more_fragments
);

    // Start strobe lines up with the freshly loaded descriptor
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hdr_start_tx <= 1'b0;
        end else begin
            hdr_start_tx <= hdr_load;
        end
    end

    // Descriptor holds until the next load
    always_ff @(posedge aclk) begin
        if (hdr_load) begin
            hdr_rdma_remote_addr <= frag_remote_addr;
            hdr_rdma_length      <= frag_len;
            hdr_fragment_id      <= frag_id;
            hdr_more_fragments   <= frag_more;
        end
    end

    a_start_single: assert property (@(posedge aclk) disable iff (!aresetn)
        hdr_start_tx |=> !hdr_start_tx);

endmodule

`default_nettype wire

/* verilog/send_cmd_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module send_cmd_latch (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire                         tx_cmd_valid,
    output logic                        tx_cmd_ready,
    input  wire tx_stream_pkg::sq_idx_t tx_cmd_sq_index,
    input  wire tx_stream_pkg::addr_t   tx_cmd_ddr_addr,
    input  wire tx_stream_pkg::len_t    tx_cmd_length,
    input  wire tx_stream_pkg::opcode_t tx_cmd_opcode,
    input  wire tx_stream_pkg::psn_t    tx_cmd_psn,
    input  wire tx_stream_pkg::qpn_t    tx_cmd_dest_qp,
    input  wire tx_stream_pkg::raddr_t  tx_cmd_remote_addr,
    input  wire tx_stream_pkg::rkey_t   tx_cmd_rkey,
    input  wire                         cmd_release,
    output logic                        cmd_accept,
    output tx_stream_pkg::sq_idx_t      sq_index,
    output tx_stream_pkg::addr_t        ddr_addr,
    output tx_stream_pkg::len_t         length,
    output tx_stream_pkg::opcode_t      opcode,
    output tx_stream_pkg::psn_t         psn,
    output tx_stream_pkg::qpn_t         dest_qp,
    output tx_stream_pkg::raddr_t       remote_addr,
    output tx_stream_pkg::rkey_t        rkey
);

    logic busy;

    // Only one message in flight, completion must be taken first
    assign tx_cmd_ready = !busy;
    assign cmd_accept   = tx_cmd_valid && tx_cmd_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy <= 1'b0;
        end else if (cmd_accept) begin
            busy <= 1'b1;
        end else if (cmd_release) begin
            busy <= 1'b0;
        end
    end

    // Command fields, held for the whole message
    always_ff @(posedge aclk) begin
        if (cmd_accept) begin
            sq_index    <= tx_cmd_sq_index;
            ddr_addr    <= tx_cmd_ddr_addr;
            length      <= tx_cmd_length;
            opcode      <= tx_cmd_opcode;
            psn         <= tx_cmd_psn;
            dest_qp     <= tx_cmd_dest_qp;
            remote_addr <= tx_cmd_remote_addr;
            rkey        <= tx_cmd_rkey;
        end
    end

    a_no_zero_length: assert property (@(posedge aclk) disable iff (!aresetn)
        cmd_accept |-> tx_cmd_length != '0);

    // Release only closes a message that was opened earlier
    a_release_when_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        cmd_release |-> busy);

endmodule

`default_nettype wire

/* verilog/tx_stream_pkg.sv */
`default_nettype none

package tx_stream_pkg;

    //////////////////////////////////////////////////
    // Command and header field types
    //////////////////////////////////////////////////

    // DDR side
    typedef logic [31:0] addr_t;
    typedef logic [31:0] len_t;
    typedef logic [7:0]  sq_idx_t;

    // RDMA header fields
    typedef logic [7:0]  opcode_t;
    typedef logic [23:0] psn_t;
    typedef logic [23:0] qpn_t;
    typedef logic [63:0] raddr_t;
    typedef logic [31:0] rkey_t;
    typedef logic [15:0] frag_id_t;

    //////////////////////////////////////////////////
    // Data mover MM2S command
    //////////////////////////////////////////////////

    typedef logic [22:0] btt_t;
    typedef logic [71:0] dm_cmd_t;

    // Bits 24..29 and 64..71 are reserved and sent as zero
    localparam int DM_BTT_LSB  = 0;
    localparam int DM_EOF_BIT  = 23;
    localparam int DM_DSA_BIT  = 30;
    localparam int DM_TYPE_BIT = 31;
    localparam int DM_ADDR_LSB = 32;

endpackage

`default_nettype wire

/* verilog/tx_streamer.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_streamer #(
    parameter int BLOCK_SIZE    = 1024,
    parameter int BOUNDARY_SIZE = 1024
) (
    input  wire                          aclk,
    input  wire                          aresetn,
    // Send command
    input  wire                          tx_cmd_valid,
    output wire                          tx_cmd_ready,
    input  wire tx_stream_pkg::sq_idx_t  tx_cmd_sq_index,
    input  wire tx_stream_pkg::addr_t    tx_cmd_ddr_addr,
    input  wire tx_stream_pkg::len_t     tx_cmd_length,
    input  wire tx_stream_pkg::opcode_t  tx_cmd_opcode,
    input  wire tx_stream_pkg::psn_t     tx_cmd_psn,
    input  wire tx_stream_pkg::qpn_t     tx_cmd_dest_qp,
    input  wire tx_stream_pkg::raddr_t   tx_cmd_remote_addr,
    input  wire tx_stream_pkg::rkey_t    tx_cmd_rkey,
    // Completion
    output wire                          tx_cpl_valid,
    input  wire                          tx_cpl_ready,
    output wire tx_stream_pkg::sq_idx_t  tx_cpl_sq_index,
    output wire tx_stream_pkg::len_t     tx_cpl_bytes_sent,
    // Header inserter
    output wire                          hdr_start_tx,
    input  wire                          hdr_tx_busy,
    input  wire                          hdr_tx_done,
    output wire tx_stream_pkg::opcode_t  hdr_rdma_opcode,
    output wire tx_stream_pkg::psn_t     hdr_rdma_psn,
    output wire tx_stream_pkg::qpn_t     hdr_rdma_dest_qp,
    output wire tx_stream_pkg::raddr_t   hdr_rdma_remote_addr,
    output wire tx_stream_pkg::rkey_t    hdr_rdma_rkey,
    output wire tx_stream_pkg::len_t     hdr_rdma_length,
    output wire tx_stream_pkg::frag_id_t hdr_fragment_id,
    output wire                          hdr_more_fragments,
    // Data mover
    output wire tx_stream_pkg::dm_cmd_t  m_axis_mm2s_cmd_tdata,
    output wire                          m_axis_mm2s_cmd_tvalid,
    input  wire                          m_axis_mm2s_cmd_tready,
    input  wire                          mm2s_rd_xfer_cmplt
);

    wire                          cmd_accept;
    wire                          cmd_release;
    wire tx_stream_pkg::addr_t    ddr_addr;
    wire tx_stream_pkg::len_t     length;
    wire tx_stream_pkg::raddr_t   remote_addr;
    wire                          hdr_load;
    wire tx_stream_pkg::raddr_t   frag_remote_addr;
    wire tx_stream_pkg::len_t     frag_len;
    wire tx_stream_pkg::frag_id_t frag_id;
    wire                          frag_more;
    wire                          dm_issue;
    wire tx_stream_pkg::addr_t    dm_addr;
    wire tx_stream_pkg::btt_t     dm_btt;

    // Per-message fields go straight to the header inserter
    send_cmd_latch u_send_cmd_latch (
        .sq_index (tx_cpl_sq_index),
        .opcode   (hdr_rdma_opcode),
        .psn      (hdr_rdma_psn),
        .dest_qp  (hdr_rdma_dest_qp),
        .rkey     (hdr_rdma_rkey),
        .*
    );

    fragment_engine #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .BOUNDARY_SIZE (BOUNDARY_SIZE)
    ) u_fragment_engine (
        .*
    );

    hdr_desc_regs u_hdr_desc_regs (
        .*
    );

    dm_cmd_builder u_dm_cmd_builder (
        .*
    );

endmodule

`default_nettype wire
